//--- common/decodePkg.sv
package decodePkg;

    localparam int xlen         = 32;
    localparam int aluCtrlWidth = 5;

    // RV32 major opcodes
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

    localparam logic [1:0] aluOpAdd    = 2'b00;   // address add
    localparam logic [1:0] aluOpBranch = 2'b01;   // subtract for compare
    localparam logic [1:0] aluOpFunct  = 2'b10;   // look at funct fields

    localparam logic [2:0] immI = 3'd0;
    localparam logic [2:0] immS = 3'd1;
    localparam logic [2:0] immB = 3'd2;
    localparam logic [2:0] immJ = 3'd3;
    localparam logic [2:0] immU = 3'd4;

    localparam logic [2:0] resAlu     = 3'd0;
    localparam logic [2:0] resMem     = 3'd1;
    localparam logic [2:0] resPcPlus4 = 3'd2;
    localparam logic [2:0] resImm     = 3'd3;   // lui
    localparam logic [2:0] resPcImm   = 3'd4;   // auipc

    // load/store width, bit 2 marks zero extension
    localparam logic [2:0] sizeWord  = 3'b000;
    localparam logic [2:0] sizeByte  = 3'b001;
    localparam logic [2:0] sizeHalf  = 3'b010;
    localparam logic [2:0] sizeByteU = 3'b101;
    localparam logic [2:0] sizeHalfU = 3'b110;

    localparam logic [aluCtrlWidth-1:0] aluAdd    = 5'd0;
    localparam logic [aluCtrlWidth-1:0] aluSub    = 5'd1;
    localparam logic [aluCtrlWidth-1:0] aluSll    = 5'd2;
    localparam logic [aluCtrlWidth-1:0] aluSlt    = 5'd3;
    localparam logic [aluCtrlWidth-1:0] aluSltu   = 5'd4;
    localparam logic [aluCtrlWidth-1:0] aluXor    = 5'd5;
    localparam logic [aluCtrlWidth-1:0] aluSrl    = 5'd6;
    localparam logic [aluCtrlWidth-1:0] aluSra    = 5'd7;
    localparam logic [aluCtrlWidth-1:0] aluOr     = 5'd8;
    localparam logic [aluCtrlWidth-1:0] aluAnd    = 5'd9;
    // M extension
    localparam logic [aluCtrlWidth-1:0] aluMul    = 5'd10;
    localparam logic [aluCtrlWidth-1:0] aluMulh   = 5'd11;
    localparam logic [aluCtrlWidth-1:0] aluMulhsu = 5'd12;
    localparam logic [aluCtrlWidth-1:0] aluMulhu  = 5'd13;
    localparam logic [aluCtrlWidth-1:0] aluDiv    = 5'd14;
    localparam logic [aluCtrlWidth-1:0] aluDivu   = 5'd15;
    localparam logic [aluCtrlWidth-1:0] aluRem    = 5'd16;
    localparam logic [aluCtrlWidth-1:0] aluRemu   = 5'd17;

endpackage

//--- compile.f
common/decodePkg.sv
verilog/MainDecoder.sv
verilog/AluDecoder.sv
verilog/ImmExtend.sv
verilog/DecodeStage.sv
test/DecodeStageTb.sv

//--- run.sh
#!/bin/sh
# build the decode stage testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module DecodeStageTb \
    -f compile.f -o simDecodeStage \
    && ./obj_dir/simDecodeStage | tee sim.log \
    && grep -q "Test passed" sim.log \
    && echo "run.sh: simulation PASS" \
    || { echo "run.sh: simulation FAIL"; exit 1; }

//--- test/DecodeStageTb.sv
module DecodeStageTb
    import decodePkg::*;
();

    localparam int clkPeriod    = 8;
    localparam int resetCycles  = 16;
    localparam int randomCycles = 2000;
    localparam int burstLength  = 200;
    localparam int watchdogTime =
        (resetCycles + randomCycles + burstLength + 8) * clkPeriod + 400;

    typedef struct packed {
        logic                    ctrlValid;
        logic                    branch;
        logic                    memWrite;
        logic                    aluSrc;
        logic                    regWrite;
        logic                    jump;
        logic                    pcTargetSrc;
        logic                    illegal;
        logic [2:0]              resultSrc;
        logic [2:0]              accessSize;
        logic [aluCtrlWidth-1:0] aluControl;
        logic [xlen-1:0]         immExt;
        logic [4:0]              rs1;
        logic [4:0]              rs2;
        logic [4:0]              rd;
        logic [2:0]              branchCond;
    } ctrlBundle;

    logic                    clk;
    logic                    arstN;
    logic                    instrValid;
    logic [31:0]             instr;
    logic                    ctrlValid, branch, memWrite, aluSrc, regWrite;
    logic                    jump, pcTargetSrc, illegal;
    logic [2:0]              resultSrc, accessSize, branchCond;
    logic [aluCtrlWidth-1:0] aluControl;
    logic [xlen-1:0]         immExt;
    logic [4:0]              rs1, rs2, rd;

    logic [15:0] lfsrState = 16'd92;
    ctrlBundle   expCur;
    logic        pendValid;
    logic        havePayload;
    int          checks = 0;
    int          errors = 0;
    int          validSeen = 0;

    DecodeStage DUT (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
        .ctrlValid(ctrlValid), .branch(branch), .memWrite(memWrite), .aluSrc(aluSrc),
        .regWrite(regWrite), .jump(jump), .pcTargetSrc(pcTargetSrc), .illegal(illegal),
        .resultSrc(resultSrc), .accessSize(accessSize), .aluControl(aluControl),
        .immExt(immExt), .rs1(rs1), .rs2(rs2), .rd(rd), .branchCond(branchCond)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    function automatic logic isLegalOp(input logic [6:0] op);
        case (op)
            opLoad, opStore, opOp, opBranch, opOpImm: return 1'b1;
            opJal, opJalr, opLui, opAuipc:            return 1'b1;
            default:                                  return 1'b0;
        endcase
    endfunction

    function automatic logic [6:0] opFromIndex(input logic [3:0] idx);
        case (idx)
            4'd0:    return opLoad;
            4'd1:    return opStore;
            4'd2:    return opOp;
            4'd3:    return opBranch;
            4'd4:    return opOpImm;
            4'd5:    return opJal;
            4'd6:    return opJalr;
            4'd7:    return opLui;
            default: return opAuipc;
        endcase
    endfunction

    task automatic genInstr(output logic [31:0] ins);
        logic [31:0] r;
        logic [6:0]  op;
        takeBits(4, r);
        if (r[3:0] == 4'd0) begin
            op = opLoad;
            while (isLegalOp(op)) begin   // one in sixteen is junk
                takeBits(7, r);
                op = r[6:0];
            end
        end else begin
            takeBits(4, r);
            while (r[3:0] > 4'd8) takeBits(4, r);
            op = opFromIndex(r[3:0]);
        end
        takeBits(25, r);
        ins = {r[24:0], op};
        if (op == opOp || op == opOpImm) begin
            takeBits(2, r);   // steer funct7 towards base, alt and M forms
            case (r[1:0])
                2'd0:    ins[31:25] = 7'b0000000;
                2'd1:    ins[31:25] = 7'b0100000;
                2'd2:    ins[31:25] = 7'b0000001;
                default: ins[31:25] = ins[31:25];
            endcase
        end
    endtask

    function automatic logic [2:0] sizeFor(input logic isLoad, input logic [2:0] f3);
        case (f3)
            3'd0:    return sizeByte;
            3'd1:    return sizeHalf;
            3'd4:    return isLoad ? sizeByteU : sizeWord;
            3'd5:    return isLoad ? sizeHalfU : sizeWord;
            default: return sizeWord;
        endcase
    endfunction

    function automatic logic [aluCtrlWidth-1:0] functAlu(input logic [31:0] ins);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       isR;
        f3 = ins[14:12];
        f7 = ins[31:25];
        isR = (ins[6:0] == opOp);
        if (isR && f7 == 7'b0000001) begin
            case (f3)
                3'd0:    return aluMul;
                3'd1:    return aluMulh;
                3'd2:    return aluMulhsu;
                3'd3:    return aluMulhu;
                3'd4:    return aluDiv;
                3'd5:    return aluDivu;
                3'd6:    return aluRem;
                default: return aluRemu;
            endcase
        end
        case (f3)
            3'd0:    return (isR && f7[5]) ? aluSub : aluAdd;
            3'd1:    return aluSll;
            3'd2:    return aluSlt;
            3'd3:    return aluSltu;
            3'd4:    return aluXor;
            3'd5:    return f7[5] ? aluSra : aluSrl;
            3'd6:    return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    function automatic logic [xlen-1:0] immFor(input logic [2:0] fmt, input logic [31:0] ins);
        case (fmt)
            immI:    return 32'($signed(ins[31:20]));
            immS:    return 32'($signed({ins[31:25], ins[11:7]}));
            immB:    return 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            immJ:    return 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
            default: return {ins[31:12], 12'h000};
        endcase
    endfunction

    function automatic ctrlBundle refDecode(input logic [31:0] ins);
        ctrlBundle  b;
        logic [2:0] fmt;
        logic [1:0] aluKind;
        b = '0;
        fmt = immI;
        aluKind = aluOpAdd;
        b.ctrlValid = 1'b1;
        b.rs1 = ins[19:15];
        b.rs2 = ins[24:20];
        b.rd = ins[11:7];
        b.branchCond = ins[14:12];
        b.resultSrc = resAlu;
        b.accessSize = sizeWord;
        case (ins[6:0])
            opLoad: begin
                {b.regWrite, b.aluSrc} = 2'b11;
                b.resultSrc = resMem;
                b.accessSize = sizeFor(1'b1, ins[14:12]);
            end
            opStore: begin
                {b.memWrite, b.aluSrc} = 2'b11;
                fmt = immS;
                b.accessSize = sizeFor(1'b0, ins[14:12]);
            end
            opOp: begin
                b.regWrite = 1'b1;
                aluKind = aluOpFunct;
            end
            opBranch: begin
                b.branch = 1'b1;
                fmt = immB;
                aluKind = aluOpBranch;
            end
            opOpImm: begin
                {b.regWrite, b.aluSrc} = 2'b11;
                aluKind = aluOpFunct;
            end
            opJal: begin
                {b.regWrite, b.jump} = 2'b11;
                fmt = immJ;
                b.resultSrc = resPcPlus4;
            end
            opJalr: begin
                {b.regWrite, b.jump, b.aluSrc, b.pcTargetSrc} = 4'b1111;
                b.resultSrc = resPcPlus4;
            end
            opLui: begin
                b.regWrite = 1'b1;
                fmt = immU;
                b.resultSrc = resImm;
            end
            opAuipc: begin
                b.regWrite = 1'b1;
                fmt = immU;
                b.resultSrc = resPcImm;
            end
            default: b.illegal = 1'b1;
        endcase
        case (aluKind)
            aluOpBranch: b.aluControl = aluSub;
            aluOpFunct:  b.aluControl = functAlu(ins);
            default:     b.aluControl = aluAdd;
        endcase
        b.immExt = immFor(fmt, ins);
        return b;
    endfunction

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checks++;
        assert (actVal === expVal)
            else begin
                $display("Fail %s expected %h got %h at %0t", name, expVal, actVal, $time);
                errors++;
            end
    endtask

    task automatic checkBundle();
        if (ctrlValid === 1'b1) validSeen++;
        checkField("ctrlValid", 32'(expCur.ctrlValid), 32'(ctrlValid));
        checkField("regWrite", 32'(expCur.regWrite), 32'(regWrite));
        checkField("memWrite", 32'(expCur.memWrite), 32'(memWrite));
        checkField("branch", 32'(expCur.branch), 32'(branch));
        checkField("jump", 32'(expCur.jump), 32'(jump));
        checkField("illegal", 32'(expCur.illegal), 32'(illegal));
        if (havePayload) begin   // payload is unknown until the first valid
            checkField("aluSrc", 32'(expCur.aluSrc), 32'(aluSrc));
            checkField("pcTargetSrc", 32'(expCur.pcTargetSrc), 32'(pcTargetSrc));
            checkField("resultSrc", 32'(expCur.resultSrc), 32'(resultSrc));
            checkField("accessSize", 32'(expCur.accessSize), 32'(accessSize));
            checkField("aluControl", 32'(expCur.aluControl), 32'(aluControl));
            checkField("immExt", expCur.immExt, immExt);
            checkField("rs1", 32'(expCur.rs1), 32'(rs1));
            checkField("rs2", 32'(expCur.rs2), 32'(rs2));
            checkField("rd", 32'(expCur.rd), 32'(rd));
            checkField("branchCond", 32'(expCur.branchCond), 32'(branchCond));
        end
    endtask

    // check the bundle from the last edge, then drive the next instruction
    task automatic driveAndCheck(input logic v, input logic [31:0] ins);
        @(negedge clk);
        if (pendValid) checkBundle();
        instrValid = v;
        instr = ins;
        if (v) begin
            expCur = refDecode(ins);
            havePayload = 1'b1;
        end else begin
            expCur.ctrlValid = 1'b0;
            expCur.regWrite = 1'b0;
            expCur.memWrite = 1'b0;
            expCur.branch = 1'b0;
            expCur.jump = 1'b0;
            expCur.illegal = 1'b0;
        end
        pendValid = 1'b1;
    endtask

    initial begin
        #(watchdogTime);
        $display("timeout: run did not finish within %0d time units", watchdogTime);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] ins;
        logic [31:0] r;
        int          errBefore;
        int          checkBefore;
        int          seenBefore;
        int          bubbles;
        int          illegals;
        arstN = 1'b0;
        instrValid = 1'b0;
        instr = 32'h0;
        expCur = '0;
        havePayload = 1'b0;
        pendValid = 1'b0;
        bubbles = 0;
        illegals = 0;

        // valid traffic during reset must not leak through
        for (int i = 0; i < resetCycles; i++) begin
            @(negedge clk);
            checkBundle();
            genInstr(ins);
            instrValid = 1'b1;
            instr = ins;
        end
        @(negedge clk);
        checkBundle();
        arstN = 1'b1;
        instrValid = 1'b0;
        pendValid = 1'b1;
        driveAndCheck(1'b0, 32'h0);
        $display("reset test: %0d checks, %0d errors", checks, errors);

        errBefore = errors;
        checkBefore = checks;
        for (int i = 0; i < randomCycles; i++) begin
            takeBits(2, r);
            genInstr(ins);
            if (r[1:0] == 2'd0) bubbles++;
            else if (!isLegalOp(ins[6:0])) illegals++;
            driveAndCheck(r[1:0] != 2'd0, ins);
        end
        driveAndCheck(1'b0, 32'h0);
        $display("random test: %0d checks, %0d errors, %0d bubbles, %0d illegal",
                 checks - checkBefore, errors - errBefore, bubbles, illegals);

        errBefore = errors;
        checkBefore = checks;
        seenBefore = validSeen;
        for (int i = 0; i < burstLength; i++) begin
            genInstr(ins);
            driveAndCheck(1'b1, ins);
        end
        driveAndCheck(1'b0, 32'h0);
        checks++;
        assert (validSeen - seenBefore == burstLength)
            else begin
                $display("burst of %0d instructions gave %0d valid bundles",
                         burstLength, validSeen - seenBefore);
                errors++;
            end
        $display("burst test: %0d checks, %0d errors", checks - checkBefore,
                 errors - errBefore);

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog/AluDecoder.sv
module AluDecoder import decodePkg::*; (
    input  logic [1:0]              aluOp,
    input  logic [2:0]              funct3,
    input  logic [6:0]              funct7,
    input  logic                    opBit5,
    output logic [aluCtrlWidth-1:0] aluControl
);

    logic mExt;
    logic rSub;

    assign mExt = opBit5 && (funct7 == 7'b0000001);   // R-type only
    assign rSub = opBit5 && funct7[5];                 // no subi

    always_comb begin
        aluControl = aluAdd;
        case (aluOp)
            aluOpAdd: begin
                aluControl = aluAdd;
            end
            aluOpBranch: begin
                aluControl = aluSub;
            end
            aluOpFunct: begin
                if (mExt) begin
                    case (funct3)
                        3'd0:    aluControl = aluMul;
                        3'd1:    aluControl = aluMulh;
                        3'd2:    aluControl = aluMulhsu;
                        3'd3:    aluControl = aluMulhu;
                        3'd4:    aluControl = aluDiv;
                        3'd5:    aluControl = aluDivu;
                        3'd6:    aluControl = aluRem;
                        default: aluControl = aluRemu;
                    endcase
                end else begin
                    case (funct3)
                        3'd0:    aluControl = rSub ? aluSub : aluAdd;
                        3'd1:    aluControl = aluSll;
                        3'd2:    aluControl = aluSlt;
                        3'd3:    aluControl = aluSltu;
                        3'd4:    aluControl = aluXor;
                        3'd5:    aluControl = funct7[5] ? aluSra : aluSrl;   // srai too
                        3'd6:    aluControl = aluOr;
                        default: aluControl = aluAnd;
                    endcase
                end
            end
            default: begin
                aluControl = aluAdd;                   // aluOp 11 not issued
            end
        endcase
    end

endmodule

//--- verilog/DecodeStage.sv
module DecodeStage import decodePkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    instrValid,
    input  logic [31:0]             instr,
    output logic                    ctrlValid,
    output logic                    branch,
    output logic                    memWrite,
    output logic                    aluSrc,
    output logic                    regWrite,
    output logic                    jump,
    output logic                    pcTargetSrc,
    output logic                    illegal,
    output logic [2:0]              resultSrc,
    output logic [2:0]              accessSize,
    output logic [aluCtrlWidth-1:0] aluControl,
    output logic [xlen-1:0]         immExt,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd,
    output logic [2:0]              branchCond
);

    logic                    decBranch, decMemWrite, decAluSrc, decRegWrite;
    logic                    decJump, decPcTargetSrc, decIllegal;
    logic [1:0]              decAluOp;
    logic [2:0]              decImmSrc, decResultSrc, decAccessSize;
    logic [aluCtrlWidth-1:0] decAluControl;
    logic [xlen-1:0]         decImmExt;

    MainDecoder mainDec (
        .op          (instr[6:0]),
        .funct3      (instr[14:12]),
        .branch      (decBranch),
        .memWrite    (decMemWrite),
        .aluSrc      (decAluSrc),
        .regWrite    (decRegWrite),
        .jump        (decJump),
        .pcTargetSrc (decPcTargetSrc),
        .illegal     (decIllegal),
        .aluOp       (decAluOp),
        .immSrc      (decImmSrc),
        .resultSrc   (decResultSrc),
        .accessSize  (decAccessSize)
    );

    AluDecoder aluDec (
        .aluOp      (decAluOp),
        .funct3     (instr[14:12]),
        .funct7     (instr[31:25]),
        .opBit5     (instr[5]),
        .aluControl (decAluControl)
    );

    ImmExtend immGen (
        .instrBits (instr[31:7]),
        .immSrc    (decImmSrc),
        .immExt    (decImmExt)
    );

    // control half of ID/EX, a low strobe loads a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrlValid <= 1'b0;
            regWrite  <= 1'b0;
            memWrite  <= 1'b0;
            branch    <= 1'b0;
            jump      <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            ctrlValid <= instrValid;
            regWrite  <= instrValid & decRegWrite;
            memWrite  <= instrValid & decMemWrite;
            branch    <= instrValid & decBranch;
            jump      <= instrValid & decJump;
            illegal   <= instrValid & decIllegal;
        end
    end

    // payload half, held across bubbles
    always_ff @(posedge clk) begin
        if (instrValid) begin
            aluSrc      <= decAluSrc;
            pcTargetSrc <= decPcTargetSrc;
            resultSrc   <= decResultSrc;
            accessSize  <= decAccessSize;
            aluControl  <= decAluControl;
            immExt      <= decImmExt;
            rs1         <= instr[19:15];
            rs2         <= instr[24:20];
            rd          <= instr[11:7];
            branchCond  <= instr[14:12];   // for the branch unit
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        !ctrlValid |-> !(regWrite || memWrite || branch || jump))
        else $error("DecodeStage: side effect on a bubble");

    assert property (@(posedge clk) disable iff (!arstN)
        illegal |-> !(regWrite || memWrite))
        else $error("DecodeStage: illegal opcode writes state");

endmodule

//--- verilog/ImmExtend.sv
module ImmExtend import decodePkg::*; (
    input  logic [24:0]     instrBits,
    input  logic [2:0]      immSrc,
    output logic [xlen-1:0] immExt
);

    logic sign;

    // instrBits[k] is instruction bit k+7
    assign sign = instrBits[24];

    always_comb begin
        case (immSrc)
            immI: immExt = {{20{sign}}, instrBits[24:13]};
            immS: immExt = {{20{sign}}, instrBits[24:18], instrBits[4:0]};
            immB: begin
                immExt = {{20{sign}}, instrBits[0], instrBits[23:18],
                          instrBits[4:1], 1'b0};
            end
            immJ: begin
                immExt = {{12{sign}}, instrBits[12:5], instrBits[13],
                          instrBits[23:14], 1'b0};
            end
            immU:    immExt = {instrBits[24:5], 12'b0};
            default: immExt = '0;
        endcase
    end

endmodule

//--- verilog/MainDecoder.sv
module MainDecoder import decodePkg::*; (
    input  logic [6:0] op,
    input  logic [2:0] funct3,
    output logic       branch,
    output logic       memWrite,
    output logic       aluSrc,
    output logic       regWrite,
    output logic       jump,
    output logic       pcTargetSrc,
    output logic       illegal,
    output logic [1:0] aluOp,
    output logic [2:0] immSrc,
    output logic [2:0] resultSrc,
    output logic [2:0] accessSize
);

    always_comb begin
        branch      = 1'b0;
        memWrite    = 1'b0;
        aluSrc      = 1'b0;
        regWrite    = 1'b0;
        jump        = 1'b0;
        pcTargetSrc = 1'b0;
        illegal     = 1'b0;
        aluOp       = aluOpAdd;
        immSrc      = immI;
        resultSrc   = resAlu;
        accessSize  = sizeWord;

        case (op)
            opLoad: begin
                case (funct3)
                    3'd0:    accessSize = sizeByte;    // lb
                    3'd1:    accessSize = sizeHalf;    // lh
                    3'd2:    accessSize = sizeWord;    // lw
                    3'd4:    accessSize = sizeByteU;   // lbu
                    3'd5:    accessSize = sizeHalfU;   // lhu
                    default: accessSize = sizeWord;
                endcase
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                immSrc    = immI;
                resultSrc = resMem;
            end
            opStore: begin
                case (funct3)
                    3'd0:    accessSize = sizeByte;    // sb
                    3'd1:    accessSize = sizeHalf;    // sh
                    3'd2:    accessSize = sizeWord;    // sw
                    default: accessSize = sizeWord;
                endcase
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immS;
            end
            opOp: begin                                // also covers mul/div
                regWrite = 1'b1;
                aluOp    = aluOpFunct;
            end
            opBranch: begin
                branch = 1'b1;
                immSrc = immB;
                aluOp  = aluOpBranch;
            end
            opOpImm: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immI;
                aluOp    = aluOpFunct;
            end
            opJal: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immSrc    = immJ;
                resultSrc = resPcPlus4;
            end
            opJalr: begin
                regWrite    = 1'b1;
                jump        = 1'b1;
                aluSrc      = 1'b1;
                pcTargetSrc = 1'b1;                    // target from rs1 + imm
                immSrc      = immI;
                resultSrc   = resPcPlus4;
            end
            opLui: begin
                regWrite  = 1'b1;
                immSrc    = immU;
                resultSrc = resImm;
            end
            opAuipc: begin
                regWrite  = 1'b1;
                immSrc    = immU;
                resultSrc = resPcImm;
            end
            default: begin
                illegal = 1'b1;                        // csr, fence, system and junk
            end
        endcase
    end

endmodule
